// ==== compile.f ====
mul_pkg.sv
radix4_pp_array.sv
mul_ctrl.sv
mul_accum.sv
radix4_multiplier.sv
tb_radix4_multiplier.sv

// ==== run.sh ====
#!/bin/sh
# build and run the radix-4 multiplier testbench with Verilator
set -e

# work from the project root
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

# compile the file list into a simulation binary
verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_radix4_multiplier \
    -o sim_tb

# run and keep the log for the verdict
./obj_dir/sim_tb | tee sim.log

# verdict comes from the log
if grep -q "All checks passed" sim.log; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

// ==== tb_radix4_multiplier.sv ====
// testbench for the radix-4 multiplier: reset, directed, random, handshake and hold checks
`timescale 1ns/100ps

module tb_radix4_multiplier;
    import mul_pkg::*;

    localparam int FRAC_BITS = DEF_FRAC_BITS;
    // accepting edge to done edge, steps plus the finish cycle
    localparam int LATENCY   = DATA_W / (2 * DEF_DIGITS) + 1;
    localparam int TIMEOUT   = 50;

    logic  ctl_clk;
    logic  arst_n;
    word_t a;
    word_t b;
    logic  trigger;
    logic  ready;
    logic  done;
    word_t y;

    // expected results and their accepting edges, oldest first
    word_t exp_q[$];
    int    accept_q[$];

    int     edge_cnt = 0;
    string  cur_test = "none";
    integer seed;

    // main sequence bookkeeping
    int err_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err_start = 0;

    // checking process bookkeeping
    int    chk_errors = 0;
    int    chk_checks = 0;
    int    chk_dones = 0;
    word_t chk_exp;
    int    chk_edge;

    radix4_multiplier uut (
        .ctl_clk (ctl_clk),
        .arst_n  (arst_n),
        .a       (a),
        .b       (b),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .y       (y)
    );

    always #2 ctl_clk = ~ctl_clk;

    always @(posedge ctl_clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // expected word: full unsigned product, FRAC_BITS low bits dropped
    function automatic word_t ref_product(word_t op_a, word_t op_b);
        logic [2*DATA_W-1:0] full;
        full = {{DATA_W{1'b0}}, op_a} * {{DATA_W{1'b0}}, op_b};
        return full[FRAC_BITS +: DATA_W];
    endfunction

    // compare on the falling edge, outputs settled since the rising edge
    always @(negedge ctl_clk) begin
        if (arst_n && done) begin
            chk_dones++;
            chk_checks++;
            assert (exp_q.size() > 0) else begin
                $display("Error: test %s saw a done pulse with no operation pending", cur_test);
                chk_errors++;
            end
            if (exp_q.size() > 0) begin
                chk_exp  = exp_q.pop_front();
                chk_edge = accept_q.pop_front();
                chk_checks++;
                assert (y === chk_exp) else begin
                    $display("Error: test %s y expected %h actual %h", cur_test, chk_exp, y);
                    chk_errors++;
                end
                chk_checks++;
                assert (edge_cnt - chk_edge == LATENCY) else begin
                    $display("Error: test %s latency expected %0d actual %0d",
                             cur_test, LATENCY, edge_cnt - chk_edge);
                    chk_errors++;
                end
            end
        end
    end

    function automatic int total_errors();
        return err_count + chk_errors;
    endfunction

    // one rising edge, then the drive offset
    task automatic next_cycle();
        @(posedge ctl_clk);
        #1;
    endtask

    task automatic abort_timeout(string what);
        $display("Timeout in test %s: no %s within %0d cycles", cur_test, what, TIMEOUT);
        $display("Checks failed");
        $finish;
    endtask

    task automatic check_value(string what, word_t expected, word_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Error: test %s %s expected %h actual %h", cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready) begin
            if (n == TIMEOUT) abort_timeout("ready");
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done) begin
            if (n == TIMEOUT) abort_timeout("done pulse");
            next_cycle();
            n++;
        end
    endtask

    // every queued result checked by the comparing process
    task automatic wait_results();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == TIMEOUT) abort_timeout("result");
            next_cycle();
            n++;
        end
    endtask

    // one trigger cycle once ready is high
    task automatic issue(word_t op_a, word_t op_b);
        wait_ready();
        a       = op_a;
        b       = op_b;
        trigger = 1'b1;
        next_cycle();
        // this edge accepted the operands
        exp_q.push_back(ref_product(op_a, op_b));
        accept_q.push_back(edge_cnt);
        trigger = 1'b0;
    endtask

    task automatic run_op(word_t op_a, word_t op_b);
        issue(op_a, op_b);
        wait_results();
    endtask

    task automatic start_test(string name);
        cur_test       = name;
        test_err_start = total_errors();
    endtask

    task automatic finish_test();
        tests_run++;
        if (total_errors() == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", cur_test, total_errors() - test_err_start);
        end
    endtask

    initial begin
        word_t op_a;
        word_t op_b;
        word_t last_y;
        int    dones_before;
        int    done_edge;

        ctl_clk = 1'b0;
        arst_n  = 1'b0;
        a       = '0;
        b       = '0;
        trigger = 1'b0;
        seed    = 32'h4cad_ee4b;
        repeat (5) @(posedge ctl_clk);
        #1;
        arst_n = 1'b1;

        start_test("reset_state");
        check_value("ready", word_t'(1), word_t'(ready));
        check_value("done", '0, word_t'(done));
        check_value("y", '0, y);
        finish_test();

        start_test("directed");
        run_op(32'h0000_0000, 32'h0000_0000);
        run_op(32'h0000_0000, 32'h1234_5678);
        run_op(32'h0000_0001, 32'h0000_0001);
        // 1.0 in the output format times a value gives the value back
        run_op(32'h0000_0100, 32'h0012_3456);
        run_op(32'hffff_ffff, 32'hffff_ffff);
        run_op(32'h8000_0000, 32'h8000_0000);
        run_op(32'h8000_0000, 32'h0000_0003);
        finish_test();

        start_test("random");
        repeat (60) begin
            op_a = $random(seed);
            op_b = $random(seed);
            run_op(op_a, op_b);
        end
        finish_test();

        start_test("ignored_trigger");
        dones_before = chk_dones;
        issue(32'h0001_0000, 32'h0000_0300);
        check_value("ready while busy", '0, word_t'(ready));
        // other operands with trigger while busy
        a       = 32'hdead_beef;
        b       = 32'h0bad_f00d;
        trigger = 1'b1;
        next_cycle();
        trigger = 1'b0;
        wait_results();
        repeat (5) next_cycle();
        check_value("done pulse count", word_t'(1), word_t'(chk_dones - dones_before));
        finish_test();

        start_test("back_to_back");
        issue(32'h0000_0a00, 32'h0003_0000);
        wait_done();
        done_edge = edge_cnt;
        // ready is high in the done cycle
        issue(32'h7654_3210, 32'h0000_0ff1);
        check_value("accept edge", word_t'(done_edge + 1), word_t'(edge_cnt));
        wait_results();
        finish_test();

        start_test("hold");
        last_y = ref_product(32'h7654_3210, 32'h0000_0ff1);
        repeat (20) begin
            next_cycle();
            check_value("held y", last_y, y);
            check_value("idle done", '0, word_t'(done));
        end
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 check_count + chk_checks, total_errors());
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== radix4_multiplier.sv ====
// radix-4 multi-cycle fixed-point multiplier top level with trigger/ready/done handshake
`timescale 1ns/100ps

module radix4_multiplier #(
    parameter int DIGITS    = mul_pkg::DEF_DIGITS,
    parameter int FRAC_BITS = mul_pkg::DEF_FRAC_BITS
) (
    input  logic           ctl_clk,
    input  logic           arst_n,
    input  mul_pkg::word_t a,
    input  mul_pkg::word_t b,
    input  logic           trigger,
    output logic           ready,
    output logic           done,
    output mul_pkg::word_t y
);
    import mul_pkg::*;

    // controller strobes
    logic load;
    logic step;
    logic finish;

    // datapath to array link
    word_t                     mcand;
    logic [2*DIGITS-1:0]       mplier_slice;
    word_t                     acc_hi;
    logic [DATA_W+2*DIGITS-1:0] part_sum;

    mul_ctrl #(
        .DIGITS (DIGITS)
    ) u_ctrl (
        .ctl_clk (ctl_clk),
        .arst_n  (arst_n),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .load    (load),
        .step    (step),
        .finish  (finish)
    );

    mul_accum #(
        .DIGITS    (DIGITS),
        .FRAC_BITS (FRAC_BITS)
    ) u_accum (
        .ctl_clk      (ctl_clk),
        .arst_n       (arst_n),
        .a            (a),
        .b            (b),
        .load         (load),
        .step         (step),
        .finish       (finish),
        .mcand        (mcand),
        .mplier_slice (mplier_slice),
        .acc_hi       (acc_hi),
        .part_sum     (part_sum),
        .y            (y)
    );

    // one slice of DIGITS radix-4 digits per clock step
    radix4_pp_array #(
        .DIGITS (DIGITS)
    ) u_pp_array (
        .mcand        (mcand),
        .mplier_slice (mplier_slice),
        .acc_hi       (acc_hi),
        .part_sum     (part_sum)
    );

endmodule

// ==== mul_accum.sv ====
// multiplier datapath: operand registers, shift-accumulate product and fixed-point output
`timescale 1ns/100ps

module mul_accum #(
    parameter int DIGITS    = mul_pkg::DEF_DIGITS,
    parameter int FRAC_BITS = mul_pkg::DEF_FRAC_BITS
) (
    input  logic                                  ctl_clk,
    input  logic                                  arst_n,
    input  mul_pkg::word_t                        a,
    input  mul_pkg::word_t                        b,
    input  logic                                  load,
    input  logic                                  step,
    input  logic                                  finish,
    output mul_pkg::word_t                        mcand,
    output logic [2*DIGITS-1:0]                   mplier_slice,
    output mul_pkg::word_t                        acc_hi,
    input  logic [mul_pkg::DATA_W+2*DIGITS-1:0]   part_sum,
    output mul_pkg::word_t                        y
);
    import mul_pkg::*;

    // multiplier bits consumed per step
    localparam int SLICE_W = 2 * DIGITS;

    word_t    mcand_q;
    word_t    mplier_q;
    product_t prod_q;
    word_t    y_q;

    // new upper half from the array joined with the untouched lower half
    logic [2*DATA_W+SLICE_W-1:0] prod_cat;

    assign prod_cat = {part_sum, prod_q[DATA_W-1:0]};

    assign mcand        = mcand_q;
    assign mplier_slice = mplier_q[SLICE_W-1:0];
    assign acc_hi       = prod_q[2*DATA_W-1:DATA_W];
    assign y            = y_q;

    // operand and product registers
    always_ff @(posedge ctl_clk) begin
        if (load) begin
            mcand_q  <= a;
            mplier_q <= b;
            prod_q   <= '0;
        end else if (step) begin
            // next slice of multiplier digits moves to the bottom
            mplier_q <= mplier_q >> SLICE_W;
            // sum goes on top, finished low bits slide down one slice
            prod_q   <= prod_cat[2*DATA_W+SLICE_W-1:SLICE_W];
        end
    end

    // output word, held until the next finish
    always_ff @(posedge ctl_clk or negedge arst_n) begin
        if (!arst_n) begin
            y_q <= '0;
        end else if (finish) begin
            // drop FRAC_BITS low bits, keep one word above them
            y_q <= prod_q[FRAC_BITS +: DATA_W];
        end
    end

    // host must present known operands on the accepting edge
    a_known_operands : assert property (
        @(posedge ctl_clk) disable iff (!arst_n) load |-> !$isunknown({a, b})
    );

endmodule

// ==== mul_ctrl.sv ====
// multiplier controller: state machine, step counter, ready/done and datapath strobes
`timescale 1ns/100ps

module mul_ctrl #(
    parameter int DIGITS = mul_pkg::DEF_DIGITS
) (
    input  logic ctl_clk,
    input  logic arst_n,
    input  logic trigger,
    output logic ready,
    output logic done,
    output logic load,
    output logic step,
    output logic finish
);
    import mul_pkg::*;

    // clock steps per operation, 4 with the defaults
    localparam int        STEPS    = DATA_W / (2 * DIGITS);
    localparam step_cnt_t LAST_CNT = step_cnt_t'(STEPS);

    mul_state_e state_q;
    mul_state_e state_d;
    step_cnt_t  cnt_q;
    logic       done_q;

    // host may start a new operation in idle or in the done cycle
    assign ready = (state_q == st_idle) || (state_q == st_done);

    // accepted trigger loads operands and clears the product
    assign load = ready && trigger;

    // accumulate while steps remain
    assign step = (state_q == st_calc) && (cnt_q < LAST_CNT);

    // one extra calc cycle to latch the output slice
    assign finish = (state_q == st_calc) && (cnt_q == LAST_CNT);

    assign done = done_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (trigger) begin
                    state_d = st_calc;
                end
            end
            st_calc: begin
                // counter at step count means finish is high this cycle
                if (cnt_q == LAST_CNT) begin
                    state_d = st_done;
                end
            end
            st_done: begin
                // back-to-back start, or drop to idle
                if (trigger) begin
                    state_d = st_calc;
                end else begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge ctl_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // restart count on every accepted operation
            if (load) begin
                cnt_q <= '0;
            end else if (step) begin
                cnt_q <= cnt_q + step_cnt_t'(1);
            end
            // done lands on the same edge as the output word
            done_q <= finish;
        end
    end

    // done is a single-cycle pulse even with back-to-back operations
    a_done_pulse : assert property (
        @(posedge ctl_clk) disable iff (!arst_n) done |=> !done
    );

    // accumulation runs on into the finish cycle, host kept waiting throughout
    a_step_busy : assert property (
        @(posedge ctl_clk) disable iff (!arst_n) step |=> (step || finish) && !ready
    );

endmodule

// ==== radix4_pp_array.sv ====
// radix-4 partial product chain: adds one multiplier slice times the multiplicand to acc_hi
`timescale 1ns/100ps

module radix4_pp_array #(
    parameter int DIGITS = mul_pkg::DEF_DIGITS
) (
    input  mul_pkg::word_t                           mcand,
    input  logic [2*DIGITS-1:0]                      mplier_slice,
    input  mul_pkg::word_t                           acc_hi,
    output logic [mul_pkg::DATA_W+2*DIGITS-1:0]      part_sum
);
    import mul_pkg::*;

    // one row is the multiplicand plus two guard bits
    // 3*mcand + (previous row >> 2) still fits in this width
    typedef logic [DATA_W+1:0] row_t;

    // multiple table, x0 and x1 need no logic
    row_t mult_x2;
    row_t mult_x3;

    // running sum after each digit
    row_t row_sum [DIGITS];

    // x2 is a plain shift
    assign mult_x2 = {1'b0, mcand, 1'b0};

    // x3 needs the one real adder of the table
    assign mult_x3 = {2'b00, mcand} + mult_x2;

    for (genvar i = 0; i < DIGITS; i++) begin : g_row
        logic [1:0] digit;
        row_t       multiple;
        row_t       prev;

        // digit i of this slice, lsb first
        assign digit = mplier_slice[2*i +: 2];

        // pick the multiple for this digit
        always_comb begin
            case (digit)
                2'b00:   multiple = '0;
                2'b01:   multiple = {2'b00, mcand};
                2'b10:   multiple = mult_x2;
                default: multiple = mult_x3;
            endcase
        end

        if (i == 0) begin : g_first
            // upper product half enters as the starting row
            assign prev = {2'b00, acc_hi};
        end else begin : g_next
            // previous row moved down by one radix-4 digit
            assign prev = {2'b00, row_sum[i-1][DATA_W+1:2]};
        end

        assign row_sum[i] = multiple + prev;

        // two low bits of each row are final product bits
        assign part_sum[2*i +: 2] = row_sum[i][1:0];
    end

    // top of the last row forms the new upper half
    assign part_sum[2*DIGITS +: DATA_W] = row_sum[DIGITS-1][DATA_W+1:2];

endmodule

// ==== mul_pkg.sv ====
// radix-4 multiplier package: word width, defaults, vector types and controller states
package mul_pkg;

    // operand and result width, fixed for the whole design
    localparam int DATA_W = 32;

    // radix-4 digits handled per clock step
    // DATA_W has to divide evenly by 2*DIGITS
    localparam int DEF_DIGITS = 4;

    // low product bits dropped from the output word
    // valid range 0 .. DATA_W
    localparam int DEF_FRAC_BITS = 8;

    // operand or result word
    typedef logic [DATA_W-1:0] word_t;

    // full double-width product
    typedef logic [2*DATA_W-1:0] product_t;

    // step counter
    // 8 bits covers any legal digit count
    typedef logic [7:0] step_cnt_t;

    // controller states
    // st_idle  waiting for trigger, ready high
    // st_calc  shift-accumulate steps, then the finish cycle
    // st_done  result valid, ready high, new trigger accepted
    typedef enum logic [1:0] {
        st_idle = 2'h0,
        st_calc = 2'h1,
        st_done = 2'h2
    } mul_state_e;

endpackage
